//--- source/bp_pkg.sv
// Next-PC predictor shared types, sizes and encodings

package bp_pkg;

  ////////////////////////////////////////
  // Sizes and constants
  ////////////////////////////////////////

  localparam int XLEN = 32;

  // Return address stack depth and occupancy counter width
  localparam int RAS_DEPTH = 16;
  localparam int RAS_CNT_W = 5;

  // Fetch address after reset
  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_1000;

  // Link registers per the calling convention (ra and t0)
  localparam logic [4:0] LINK_RA = 5'd1;
  localparam logic [4:0] LINK_T0 = 5'd5;

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  // Major opcodes of interest, RV32I base encoding
  typedef enum logic [6:0] {
    OPC_BRANCH = 7'b1100011,
    OPC_JALR   = 7'b1100111,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [1:0] {KIND_OTHER, KIND_BRANCH, KIND_JAL, KIND_JALR} instr_kind_e;

  typedef enum logic [1:0] {RAS_NONE, RAS_PUSH, RAS_POP, RAS_BOTH} ras_op_e;

  typedef enum logic [1:0] {SRC_SEQ, SRC_RAS, SRC_JAL, SRC_BRANCH} pred_src_e;

  ////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////

  // Predecode result of the fetched instruction
  typedef struct packed {
    instr_kind_e     kind;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [XLEN-1:0] target;    // PC + J/B immediate
    logic            backward;  // Branch offset is negative
    logic [XLEN-1:0] ret_addr;  // PC + 4
  } predecode_t;

  // Backend redirect
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
  } redirect_t;

  // Prediction reported to fetch
  typedef struct packed {
    logic            taken;
    pred_src_e       src;
    logic [XLEN-1:0] target;
  } pred_t;

endpackage

//--- source/jump_predecoder.sv
// Jump predecoder: classifies the fetched word and computes jump/branch targets
`timescale 1ns/1ps

module jump_predecoder
  import bp_pkg::*;
(
  input  logic [XLEN-1:0] pc_i,
  input  logic [XLEN-1:0] instr_i,
  output predecode_t      dec_o
);

  ////////////////////////////////////////
  // Field extraction
  ////////////////////////////////////////

  logic [6:0]      opcode;
  logic [4:0]      rd;
  logic [4:0]      rs1;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] ret_addr;
  logic [XLEN-1:0] jal_target;
  logic [XLEN-1:0] br_target;
  instr_kind_e     kind;

  assign opcode = instr_i[6:0];

  // Register fields sit at fixed positions in every format
  assign rd  = instr_i[11:7];
  assign rs1 = instr_i[19:15];

  // J-type immediate, bit 0 implied zero
  assign imm_j = {{12{instr_i[31]}},
                  instr_i[19:12],
                  instr_i[20],
                  instr_i[30:21],
                  1'b0};

  // B-type immediate, bit 0 implied zero
  assign imm_b = {{20{instr_i[31]}},
                  instr_i[7],
                  instr_i[30:25],
                  instr_i[11:8],
                  1'b0};

  ////////////////////////////////////////
  // Target arithmetic
  ////////////////////////////////////////

  // No compressed support so the link is always PC+4
  assign ret_addr   = pc_i + 32'd4;
  assign jal_target = pc_i + imm_j;
  assign br_target  = pc_i + imm_b;

  ////////////////////////////////////////
  // Classification
  ////////////////////////////////////////

  always_comb begin
    case (opcode)
      OPC_JAL:    kind = KIND_JAL;
      // funct3 is not checked, any JALR-opcode word counts
      OPC_JALR:   kind = KIND_JALR;
      OPC_BRANCH: kind = KIND_BRANCH;
      default:    kind = KIND_OTHER;
    endcase
  end

  ////////////////////////////////////////
  // Output bundle
  ////////////////////////////////////////

  always_comb begin
    dec_o.kind     = kind;
    dec_o.rd       = rd;
    dec_o.rs1      = rs1;
    dec_o.ret_addr = ret_addr;

    // Target depends on format; JALR target comes from the RAS instead
    case (kind)
      KIND_JAL:    dec_o.target = jal_target;
      KIND_BRANCH: dec_o.target = br_target;
      default:     dec_o.target = ret_addr;
    endcase

    // Sign of the B immediate marks a backward branch
    dec_o.backward = (kind == KIND_BRANCH) && instr_i[31];
  end

endmodule

//--- source/return_stack.sv
// Return address stack: call/return detection, shift storage and occupancy count
`timescale 1ns/1ps

module return_stack
  import bp_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            upd_i,
  input  predecode_t      dec_i,
  output logic [XLEN-1:0] ras_top_o,
  output logic            ras_hit_o
);

  // Entry 0 is the top of stack
  logic [XLEN-1:0]      stack_q [RAS_DEPTH];
  logic [RAS_CNT_W-1:0] cnt_q;
  ras_op_e              ras_op;
  logic                 link_rd;
  logic                 link_rs1;
  logic                 cnt_empty;
  logic                 cnt_full;

  ////////////////////////////////////////
  // Push/pop decision
  ////////////////////////////////////////

  assign link_rd  = (dec_i.rd == LINK_RA) || (dec_i.rd == LINK_T0);
  assign link_rs1 = (dec_i.rs1 == LINK_RA) || (dec_i.rs1 == LINK_T0);

  always_comb begin
    ras_op = RAS_NONE;
    if (dec_i.kind == KIND_JAL) begin
      // Direct call
      if (link_rd) ras_op = RAS_PUSH;
    end else if (dec_i.kind == KIND_JALR) begin
      if (link_rd && link_rs1) begin
        // Same link reg is a call, different ones are a coroutine swap
        ras_op = (dec_i.rd == dec_i.rs1) ? RAS_PUSH : RAS_BOTH;
      end else if (link_rs1) begin
        ras_op = RAS_POP;
      end else if (link_rd) begin
        ras_op = RAS_PUSH;
      end
    end
  end

  assign cnt_empty = (cnt_q == '0);
  assign cnt_full  = (cnt_q == RAS_CNT_W'(RAS_DEPTH));

  // Predict only when something was actually pushed before
  assign ras_top_o = stack_q[0];
  assign ras_hit_o = (ras_op inside {RAS_POP, RAS_BOTH}) && !cnt_empty;

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (upd_i) begin
      case (ras_op)
        RAS_PUSH: begin
          // Oldest entry falls off the bottom
          for (int i = RAS_DEPTH - 1; i > 0; i--) begin
            stack_q[i] <= stack_q[i-1];
          end
          stack_q[0] <= dec_i.ret_addr;
        end
        RAS_POP: begin
          // Bottom entry keeps its stale value
          for (int i = 0; i < RAS_DEPTH - 1; i++) begin
            stack_q[i] <= stack_q[i+1];
          end
        end
        RAS_BOTH: stack_q[0] <= dec_i.ret_addr;
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////
  // Occupancy count
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      cnt_q <= '0;
    end else if (upd_i) begin
      case (ras_op)
        RAS_PUSH: if (!cnt_full) cnt_q <= cnt_q + 1'b1;
        RAS_POP:  if (!cnt_empty) cnt_q <= cnt_q - 1'b1;
        // Pop and push together leave the depth as it was
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Count saturates at the physical depth
  a_cnt_bound: assert property (@(posedge clk_i) disable iff (rst_ni)
    cnt_q <= RAS_CNT_W'(RAS_DEPTH));

  // No stack activity without a fetch update from the PC generator
  a_hold_no_upd: assert property (@(posedge clk_i) disable iff (rst_ni)
    !upd_i |=> $stable(cnt_q) && $stable(stack_q[0]));

endmodule

//--- source/fetch_pc_gen.sv
// Fetch PC generator: PC register and prioritized next-PC selection
`timescale 1ns/1ps

module fetch_pc_gen
  import bp_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            fetch_valid_i,
  input  logic            stall_i,
  input  redirect_t       redirect_i,
  input  predecode_t      dec_i,
  input  logic [XLEN-1:0] ras_top_i,
  input  logic            ras_hit_i,
  output logic            upd_o,
  output logic [XLEN-1:0] pc_o,
  output pred_t           pred_o
);

  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] pc_d;
  logic            fetch_go;

  ////////////////////////////////////////
  // Advance conditions
  ////////////////////////////////////////

  // Fetch consumed this cycle
  assign fetch_go = fetch_valid_i && !stall_i;

  // Stack follows the fetch, except when the backend moves the PC
  assign upd_o = fetch_go && !redirect_i.valid;

  ////////////////////////////////////////
  // Prediction select
  ////////////////////////////////////////

  always_comb begin
    // Default is fall-through
    pred_o.taken  = 1'b0;
    pred_o.src    = SRC_SEQ;
    pred_o.target = dec_i.ret_addr;

    if (fetch_valid_i) begin
      if ((dec_i.kind == KIND_JALR) && ras_hit_i) begin
        // Return predicted from the stack top
        pred_o.taken  = 1'b1;
        pred_o.src    = SRC_RAS;
        pred_o.target = ras_top_i;
      end else if (dec_i.kind == KIND_JAL) begin
        pred_o.taken  = 1'b1;
        pred_o.src    = SRC_JAL;
        pred_o.target = dec_i.target;
      end else if ((dec_i.kind == KIND_BRANCH) && dec_i.backward) begin
        // Static rule: backward taken, forward not taken
        pred_o.taken  = 1'b1;
        pred_o.src    = SRC_BRANCH;
        pred_o.target = dec_i.target;
      end
    end
  end

  ////////////////////////////////////////
  // PC register
  ////////////////////////////////////////

  always_comb begin
    if (redirect_i.valid) begin
      pc_d = redirect_i.pc;
    end else if (fetch_go) begin
      pc_d = pred_o.target;
    end else begin
      // Stall or bubble holds the address
      pc_d = pc_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      pc_q <= RESET_PC;
    end else begin
      pc_q <= pc_d;
    end
  end

  assign pc_o = pc_q;

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Alignment is kept from cycle to cycle given aligned redirects
  // (jump and branch offsets are assumed to be word multiples)
  a_pc_aligned: assert property (@(posedge clk_i) disable iff (rst_ni)
    (pc_o[1:0] == 2'b00) && !(redirect_i.valid && (redirect_i.pc[1:0] != 2'b00))
    |=> (pc_o[1:0] == 2'b00));

endmodule

//--- source/branch_predict_top.sv
// Next-PC predictor top: predecoder, return address stack and PC generator
`timescale 1ns/1ps

module branch_predict_top
  import bp_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            fetch_valid_i,
  input  logic [XLEN-1:0] instr_i,
  input  logic            stall_i,
  input  redirect_t       redirect_i,
  output logic [XLEN-1:0] pc_o,
  output pred_t           pred_o
);

  ////////////////////////////////////////
  // Internal nets
  ////////////////////////////////////////

  predecode_t      dec;
  logic [XLEN-1:0] ras_top;
  logic            ras_hit;
  logic            ras_upd;

  ////////////////////////////////////////
  // Predecode of the fetched word
  ////////////////////////////////////////

  jump_predecoder u_predec (
    .pc_i    (pc_o),
    .instr_i (instr_i),
    .dec_o   (dec)
  );

  ////////////////////////////////////////
  // Return address stack
  ////////////////////////////////////////

  return_stack u_ras (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .upd_i     (ras_upd),
    .dec_i     (dec),
    .ras_top_o (ras_top),
    .ras_hit_o (ras_hit)
  );

  ////////////////////////////////////////
  // PC register and next-PC select
  ////////////////////////////////////////

  fetch_pc_gen u_pcgen (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fetch_valid_i (fetch_valid_i),
    .stall_i       (stall_i),
    .redirect_i    (redirect_i),
    .dec_i         (dec),
    .ras_top_i     (ras_top),
    .ras_hit_i     (ras_hit),
    .upd_o         (ras_upd),
    .pc_o          (pc_o),
    .pred_o        (pred_o)
  );

endmodule

//--- verif/tb_branch_predict.sv
// Testbench for the next-PC predictor with reference model, random fetch stream and watchdog
`timescale 1ns/1ps

module tb_branch_predict
  import bp_pkg::*;
;

  ////////////////////////////////////////
  // Run length and encodings
  ////////////////////////////////////////

  localparam int CLK_PERIOD  = 40;
  localparam int RST_CYCLES  = 10;
  localparam int DIR_CYCLES  = 80;   // Upper bound on directed steps
  localparam int RAND_CYCLES = 400;
  localparam int TEST_CYCLES = RST_CYCLES + DIR_CYCLES + RAND_CYCLES;
  localparam int WATCHDOG_NS = TEST_CYCLES * CLK_PERIOD + 2000;

  localparam logic [31:0] SEED = 32'h7a89_e437;

  // RV32I major opcodes used by the generator and the model
  localparam logic [6:0] OP_ALU    = 7'b0010011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;

  localparam redirect_t NO_REDIR = '0;

  logic        clk_i;
  logic        rst_ni;
  logic        fetch_valid_i;
  logic [31:0] instr_i;
  logic        stall_i;
  redirect_t   redirect_i;
  logic [31:0] pc_o;
  pred_t       pred_o;

  // Model stack, entry 0 on top
  logic [31:0] model_stack [RAS_DEPTH];
  int          model_cnt;

  // Model fetch address
  logic [31:0] model_pc;

  // Expected values handed from the driver to the compare process
  pred_t       exp_pred;
  logic [31:0] exp_pc;
  logic        armed;

  branch_predict_top dut_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fetch_valid_i (fetch_valid_i),
    .instr_i       (instr_i),
    .stall_i       (stall_i),
    .redirect_i    (redirect_i),
    .pc_o          (pc_o),
    .pred_o        (pred_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  ////////////////////////////////////////
  // Failure reporting and compares
  ////////////////////////////////////////

  task automatic abort_run();
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_pc(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s pc got %h expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_pred(input pred_t got, input pred_t exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s got taken %0b %s %h, expected taken %0b %s %h",
               $time, what, got.taken, got.src.name(), got.target,
               exp.taken, exp.src.name(), exp.target);
      abort_run();
    end
  endtask

  ////////////////////////////////////////
  // Instruction encoders
  ////////////////////////////////////////

  function automatic logic [31:0] enc_alu(input logic [4:0] rd);
    // addi rd, x0, 1
    return {12'd1, 5'd0, 3'b000, rd, OP_ALU};
  endfunction

  function automatic logic [31:0] enc_jal(input logic [4:0] rd, input int off);
    logic [20:0] imm;
    imm = off[20:0];
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
  endfunction

  function automatic logic [31:0] enc_jalr(input logic [4:0] rd, input logic [4:0] rs1);
    return {12'd0, rs1, 3'b000, rd, OP_JALR};
  endfunction

  function automatic logic [31:0] enc_branch(input int off);
    logic [12:0] imm;
    imm = off[12:0];
    // beq x2, x3
    return {imm[12], imm[10:5], 5'd3, 5'd2, 3'b000, imm[4:1], imm[11], OP_BRANCH};
  endfunction

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic pred_t ref_predict(input logic [31:0] pc, input logic [31:0] instr,
                                        input logic valid, input logic stall,
                                        input redirect_t redir, output logic [31:0] next_pc);
    pred_t       p;
    logic [6:0]  opc;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [31:0] imm_j;
    logic [31:0] imm_b;
    logic        rd_link;
    logic        rs1_link;
    ras_op_e     op;
    opc      = instr[6:0];
    rd       = instr[11:7];
    rs1      = instr[19:15];
    imm_j    = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    imm_b    = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    rd_link  = (rd == 5'd1) || (rd == 5'd5);
    rs1_link = (rs1 == 5'd1) || (rs1 == 5'd5);

    // Call and return hints from the link registers
    op = RAS_NONE;
    if (opc == OP_JAL && rd_link) begin
      op = RAS_PUSH;
    end else if (opc == OP_JALR) begin
      if (rd_link && rs1_link) op = (rd == rs1) ? RAS_PUSH : RAS_BOTH;
      else if (rs1_link) op = RAS_POP;
      else if (rd_link) op = RAS_PUSH;
    end

    // Fall-through unless a higher source applies
    p.taken  = 1'b0;
    p.src    = SRC_SEQ;
    p.target = pc + 32'd4;
    if (valid) begin
      if (opc == OP_JALR && (op == RAS_POP || op == RAS_BOTH) && model_cnt > 0) begin
        p.taken  = 1'b1;
        p.src    = SRC_RAS;
        p.target = model_stack[0];
      end else if (opc == OP_JAL) begin
        p.taken  = 1'b1;
        p.src    = SRC_JAL;
        p.target = pc + imm_j;
      end else if (opc == OP_BRANCH && instr[31]) begin
        p.taken  = 1'b1;
        p.src    = SRC_BRANCH;
        p.target = pc + imm_b;
      end
    end

    if (redir.valid) next_pc = redir.pc;
    else if (valid && !stall) next_pc = p.target;
    else next_pc = pc;

    // Stack moves only on a consumed fetch without redirect
    if (valid && !stall && !redir.valid) begin
      case (op)
        RAS_PUSH: begin
          for (int i = RAS_DEPTH - 1; i > 0; i--) model_stack[i] = model_stack[i-1];
          model_stack[0] = pc + 32'd4;
          if (model_cnt < RAS_DEPTH) model_cnt++;
        end
        RAS_POP: begin
          for (int i = 0; i < RAS_DEPTH - 1; i++) model_stack[i] = model_stack[i+1];
          if (model_cnt > 0) model_cnt--;
        end
        // Top replaced, depth unchanged
        RAS_BOTH: model_stack[0] = pc + 32'd4;
        default: ;
      endcase
    end
    return p;
  endfunction

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  // One fetch cycle, driven on the falling edge
  task automatic step(input logic [31:0] instr, input logic valid, input logic stall,
                      input redirect_t redir);
    logic [31:0] nxt;
    @(negedge clk_i);
    exp_pred      = ref_predict(model_pc, instr, valid, stall, redir, nxt);
    exp_pc        = nxt;
    model_pc      = nxt;
    instr_i       = instr;
    fetch_valid_i = valid;
    stall_i       = stall;
    redirect_i    = redir;
    armed         = 1'b1;
  endtask

  function automatic logic [4:0] pick_reg();
    case ($urandom_range(0, 3))
      0:       return 5'd0;
      1:       return 5'd1;
      2:       return 5'd5;
      default: return 5'd7;
    endcase
  endfunction

  function automatic logic [31:0] gen_instr();
    int off;
    off = (int'($urandom_range(0, 32)) - 16) * 4;
    case ($urandom_range(0, 9))
      0, 1, 2, 3: return enc_alu(pick_reg());
      4, 5:       return enc_jal(pick_reg(), off);
      6, 7:       return enc_jalr(pick_reg(), pick_reg());
      default:    return enc_branch(off);
    endcase
  endfunction

  ////////////////////////////////////////
  // Compare process
  ////////////////////////////////////////

  initial begin : compare_proc
    forever begin
      // Prediction settles a quarter period after the drive
      @(negedge clk_i);
      #(CLK_PERIOD / 4);
      if (armed) check_pred(pred_o, exp_pred, "prediction");
      @(posedge clk_i);
      #1;
      if (armed) check_pc(pc_o, exp_pc, "next fetch");
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Timeout: the test did not finish within %0d ns", WATCHDOG_NS);
    abort_run();
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin : main
    redirect_t rdir;
    logic      stl;
    logic      vld;
    void'($urandom(SEED));
    clk_i         = 1'b0;
    rst_ni        = 1'b1;
    fetch_valid_i = 1'b0;
    instr_i       = '0;
    stall_i       = 1'b0;
    redirect_i    = NO_REDIR;
    armed         = 1'b0;
    model_cnt     = 0;
    model_pc      = RESET_PC;
    for (int i = 0; i < RAS_DEPTH; i++) model_stack[i] = '0;

    repeat (RST_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b0;
    check_pc(pc_o, RESET_PC, "reset");

    // Sequential fetch
    repeat (4) step(enc_alu(5'd7), 1'b1, 1'b0, NO_REDIR);

    // JAL, backward and forward branches
    step(enc_jal(5'd0, 16), 1'b1, 1'b0, NO_REDIR);
    step(enc_branch(-8), 1'b1, 1'b0, NO_REDIR);
    step(enc_branch(12), 1'b1, 1'b0, NO_REDIR);

    // Nested calls, same-link push, coroutine swap, then returns
    step(enc_jal(5'd1, 64), 1'b1, 1'b0, NO_REDIR);
    step(enc_jal(5'd1, 128), 1'b1, 1'b0, NO_REDIR);
    step(enc_jalr(5'd5, 5'd5), 1'b1, 1'b0, NO_REDIR);
    step(enc_jalr(5'd1, 5'd5), 1'b1, 1'b0, NO_REDIR);
    repeat (4) step(enc_jalr(5'd0, 5'd1), 1'b1, 1'b0, NO_REDIR);

    // Overflow, 18 calls then returns past empty
    repeat (18) step(enc_jal(5'd1, 8), 1'b1, 1'b0, NO_REDIR);
    repeat (18) step(enc_jalr(5'd0, 5'd1), 1'b1, 1'b0, NO_REDIR);

    // Stalled call then the same call, with a bubble between returns
    step(enc_jal(5'd5, 32), 1'b1, 1'b1, NO_REDIR);
    step(enc_jal(5'd5, 32), 1'b1, 1'b0, NO_REDIR);
    step(enc_jalr(5'd0, 5'd5), 1'b0, 1'b0, NO_REDIR);
    step(enc_jalr(5'd0, 5'd5), 1'b1, 1'b0, NO_REDIR);
    step(enc_jalr(5'd0, 5'd5), 1'b1, 1'b0, NO_REDIR);

    // Redirect on a return keeps the stack for the next return
    rdir.valid = 1'b1;
    rdir.pc    = 32'h0000_2000;
    step(enc_jal(5'd1, 24), 1'b1, 1'b0, NO_REDIR);
    step(enc_jalr(5'd0, 5'd1), 1'b1, 1'b0, rdir);
    step(enc_jalr(5'd0, 5'd1), 1'b1, 1'b0, NO_REDIR);

    // Random stream
    for (int n = 0; n < RAND_CYCLES; n++) begin
      stl        = ($urandom_range(0, 7) == 0);
      vld        = ($urandom_range(0, 15) != 0);
      rdir.valid = ($urandom_range(0, 19) == 0);
      rdir.pc    = 32'h0000_4000 + ($urandom_range(0, 255) << 2);
      step(gen_instr(), vld, stl, rdir);
    end

    // Let the last compare complete
    @(posedge clk_i);
    #(CLK_PERIOD / 4);
    armed = 1'b0;
    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- filelist.f
source/bp_pkg.sv
source/jump_predecoder.sv
source/return_stack.sv
source/fetch_pc_gen.sv
source/branch_predict_top.sv
verif/tb_branch_predict.sv

//--- Makefile
# Verilator build and run of the next-PC predictor testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_branch_predict
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# Exit status of the simulation binary carries pass or fail
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
